// ==== Bender.yml ====
package:
  name: cart_addr

sources:
  - files:
      - logic/cart_pkg.sv
      - logic/address_map.sv
      - logic/bus_cycle_ctrl.sv
      - logic/credit_fifo.sv
      - logic/sram_port.sv
      - logic/cart_top.sv
  - target: test
    files:
      - tests/tb_cart_top.sv

// ==== compile.f ====
logic/cart_pkg.sv
logic/address_map.sv
logic/bus_cycle_ctrl.sv
logic/credit_fifo.sv
logic/sram_port.sv
logic/cart_top.sv
tests/tb_cart_top.sv

// ==== logic/address_map.sv ====
`timescale 1ns/1ps

module address_map (
  input  logic                          CLK,
  input  logic                          arst_n,
  input  cart_pkg::mapper_t             mapper,
  input  logic [cart_pkg::feat_w-1:0]   featurebits,
  input  logic [cart_pkg::addr_w-1:0]   rom_mask,
  input  logic [cart_pkg::addr_w-1:0]   saveram_mask,
  input  logic [cart_pkg::addr_w-1:0]   snes_addr_early,
  input  logic                          snes_romsel_n,
  output logic [cart_pkg::addr_w-1:0]   phys_addr,
  output logic                          rom_hit,
  output logic                          is_saveram,
  output logic                          is_writable,
  output logic                          msu_enable,
  output logic                          dma_enable,
  output logic                          srtc_enable,
  output logic                          dspx_enable,
  output logic                          dspx_a0
);

  logic [7:0]                  mapper_dec;   // One-hot, indexed by mapper code
  logic [cart_pkg::addr_w-1:0] addr_q;
  logic                        saveram_pre;
  logic                        saveram_q;
  logic                        is_rom;

  // Folded offsets, zero extended to the full width
  logic [cart_pkg::addr_w-1:0] hi_sram_off;
  logic [cart_pkg::addr_w-1:0] lo_sram_off;
  logic [cart_pkg::addr_w-1:0] menu_sram_off;
  logic [cart_pkg::addr_w-1:0] hi_rom_off;
  logic [cart_pkg::addr_w-1:0] lo_rom_off;
  logic [cart_pkg::addr_w-1:0] exhi_rom_off;

  logic dspx_win;
  logic dspx_sel;

  ////////////////////////////////////////////////////////////////////////////
  // Input registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      mapper_dec <= '0;
      saveram_q  <= 1'b0;
    end else begin
      mapper_dec <= 8'b1 << mapper;
      saveram_q  <= saveram_pre;
    end
  end

  always_ff @(posedge CLK) begin
    addr_q <= snes_addr_early;
  end

  // Save RAM test runs on the early address to get a full cycle of slack
  always_comb begin
    saveram_pre = 1'b0;
    if (mapper_dec[cart_pkg::MAP_HIROM] || mapper_dec[cart_pkg::MAP_EXHIROM]) begin
      // 20-3F / A0-BF : 6000-7FFF
      saveram_pre = ~snes_addr_early[22] & snes_addr_early[21]
                  & ~snes_addr_early[15] & (&snes_addr_early[14:13]);
    end else if (mapper_dec[cart_pkg::MAP_LOROM]) begin
      // 70-7F / F0-FF, lower half only for big ROMs
      saveram_pre = (&snes_addr_early[22:20]) & ~snes_romsel_n
                  & (~snes_addr_early[15] | ~rom_mask[21]);
    end else if (mapper_dec[cart_pkg::MAP_MENU]) begin
      saveram_pre = &snes_addr_early[23:20];  // Whole banks F0-FF
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Physical address
  ////////////////////////////////////////////////////////////////////////////

  assign hi_sram_off   = {6'd0, addr_q[20:16], addr_q[12:0]};
  assign lo_sram_off   = {4'd0, addr_q[20:16], addr_q[14:0]};
  assign menu_sram_off = {4'd0, addr_q[19:0]};

  assign hi_rom_off   = {1'b0, addr_q[22:0]};
  assign lo_rom_off   = {1'b0, ~addr_q[23], addr_q[22:16], addr_q[14:0]};  // A15 dropped
  assign exhi_rom_off = {1'b0, ~addr_q[23], addr_q[21:0]};  // Low banks on top

  always_comb begin
    phys_addr = '0;
    case (1'b1)
      mapper_dec[cart_pkg::MAP_HIROM]: begin
        phys_addr = saveram_q ? cart_pkg::saveram_base + (hi_sram_off & saveram_mask)
                              : hi_rom_off & rom_mask;
      end
      mapper_dec[cart_pkg::MAP_LOROM]: begin
        phys_addr = saveram_q ? cart_pkg::saveram_base + (lo_sram_off & saveram_mask)
                              : lo_rom_off & rom_mask;
      end
      mapper_dec[cart_pkg::MAP_EXHIROM]: begin
        phys_addr = saveram_q ? cart_pkg::saveram_base + (hi_sram_off & saveram_mask)
                              : exhi_rom_off & rom_mask;
      end
      mapper_dec[cart_pkg::MAP_MENU]: begin
        phys_addr = saveram_q ? cart_pkg::saveram_base + (menu_sram_off & saveram_mask)
                              : (hi_rom_off & rom_mask) + cart_pkg::menu_rom_base;
      end
      default: phys_addr = '0;
    endcase
  end

  // Upper half of banks 00-3F/80-BF, all of 40-7F/C0-FF
  assign is_rom      = addr_q[22] | addr_q[15];
  assign is_saveram  = saveram_q;
  assign is_writable = saveram_q;
  assign rom_hit     = is_rom | is_writable;

  ////////////////////////////////////////////////////////////////////////////
  // Peripheral register windows, system banks only
  ////////////////////////////////////////////////////////////////////////////

  assign msu_enable  = featurebits[cart_pkg::FEAT_MSU1] & ~addr_q[22]
                     & (addr_q[15:3] == 13'h0400);   // 2000-2007
  assign dma_enable  = featurebits[cart_pkg::FEAT_DMA1] & ~addr_q[22]
                     & (addr_q[15:4] == 12'h202);    // 2020-202F
  assign srtc_enable = featurebits[cart_pkg::FEAT_SRTC] & ~addr_q[22]
                     & (addr_q[15:1] == 15'h1400);   // 2800-2801

  // DSP data/status select differs between LoROM and HiROM boards
  always_comb begin
    dspx_win = 1'b0;
    dspx_sel = 1'b1;
    if (mapper_dec[cart_pkg::MAP_LOROM]) begin
      if (rom_mask[20]) begin
        dspx_win = addr_q[22] & addr_q[21] & ~addr_q[20] & ~addr_q[15];  // 60-6F
      end else begin
        dspx_win = ~addr_q[22] & addr_q[21] & addr_q[20] & addr_q[15];   // 30-3F
      end
      dspx_sel = addr_q[14];
    end else if (mapper_dec[cart_pkg::MAP_HIROM]) begin
      dspx_win = ~(|addr_q[22:20]) & ~addr_q[15] & (&addr_q[14:13]);   // 00-0F:6000
      dspx_sel = addr_q[12];
    end
  end

  assign dspx_enable = featurebits[cart_pkg::FEAT_DSPX] & dspx_win;
  assign dspx_a0     = featurebits[cart_pkg::FEAT_DSPX] ? dspx_sel : 1'b1;

endmodule

// ==== logic/bus_cycle_ctrl.sv ====
`timescale 1ns/1ps

module bus_cycle_ctrl #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                          CLK,
  input  logic                          arst_n,
  input  logic                          snes_rd_n,
  input  logic                          snes_wr_n,
  input  logic [cart_pkg::data_w-1:0]   snes_wdata,
  input  logic [cart_pkg::addr_w-1:0]   phys_addr,
  input  logic                          rom_hit,
  input  logic                          is_writable,
  input  logic                          credit_return,
  output logic                          push,
  output cart_pkg::mem_req_t            push_data,
  output logic                          overrun
);

  localparam int cnt_w = $clog2(FIFO_DEPTH + 1);

  logic                        rd_n_q;
  logic                        wr_n_q;
  logic                        cyc_start;
  logic                        cyc_pend;   // Decode of this cycle is valid now
  logic                        cyc_write;
  logic [cart_pkg::data_w-1:0] wdata_q;
  logic [cnt_w-1:0]            credits;
  logic                        issue_ok;
  logic                        have_credit;

  // First strobe edge after an idle bus
  assign cyc_start = rd_n_q & wr_n_q & (~snes_rd_n | ~snes_wr_n);

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      rd_n_q    <= 1'b1;
      wr_n_q    <= 1'b1;
      cyc_pend  <= 1'b0;
      cyc_write <= 1'b0;
    end else begin
      rd_n_q    <= snes_rd_n;
      wr_n_q    <= snes_wr_n;
      cyc_pend  <= cyc_start;
      if (cyc_start) begin
        cyc_write <= ~snes_wr_n;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (cyc_start) begin
      wdata_q <= snes_wdata;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Issue and credits
  ////////////////////////////////////////////////////////////////////////////

  // Writes into ROM space are swallowed here
  assign issue_ok    = cyc_pend & rom_hit & (~cyc_write | is_writable);
  assign have_credit = (credits != '0);
  assign push        = issue_ok & have_credit;

  always_comb begin
    push_data.phys_addr = phys_addr;
    push_data.write     = cyc_write;
    push_data.wdata     = wdata_q;
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      credits <= cnt_w'(FIFO_DEPTH);
      overrun <= 1'b0;
    end else begin
      case ({push, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;   // None or both
      endcase
      if (issue_ok && !have_credit) begin
        overrun <= 1'b1;   // Sticky
      end
    end
  end

endmodule

// ==== logic/cart_pkg.sv ====
package cart_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int addr_w = 24;  // Console and physical address
  localparam int data_w = 8;   // Console data bus
  localparam int feat_w = 16;  // Feature enable word

  ////////////////////////////////////////////////////////////////////////////
  // Mapper codes
  ////////////////////////////////////////////////////////////////////////////

  // Same encoding as the MCU mapper detection
  typedef enum logic [2:0] {
    MAP_HIROM   = 3'd0,
    MAP_LOROM   = 3'd1,
    MAP_EXHIROM = 3'd2,
    MAP_MENU    = 3'd7
  } mapper_t;

  ////////////////////////////////////////////////////////////////////////////
  // Feature bit positions in featurebits
  ////////////////////////////////////////////////////////////////////////////

  localparam int FEAT_DSPX = 0;
  localparam int FEAT_SRTC = 2;
  localparam int FEAT_MSU1 = 3;
  localparam int FEAT_DMA1 = 7;

  // Physical layout of the external memory
  localparam logic [addr_w-1:0] saveram_base  = 24'hE0_0000;  // Top 2 MB slice
  localparam logic [addr_w-1:0] menu_rom_base = 24'hC0_0000;

  ////////////////////////////////////////////////////////////////////////////
  // Memory request, one per console cycle
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [addr_w-1:0] phys_addr;
    logic              write;      // Set for console writes
    logic [data_w-1:0] wdata;      // Only meaningful with write
  } mem_req_t;

endpackage

// ==== logic/cart_top.sv ====
`timescale 1ns/1ps

module cart_top #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                          CLK,
  input  logic                          arst_n,
  // Console bus
  input  logic [cart_pkg::addr_w-1:0]   snes_addr_early,
  input  logic                          snes_rd_n,
  input  logic                          snes_wr_n,
  input  logic [cart_pkg::data_w-1:0]   snes_wdata,
  input  logic                          snes_romsel_n,
  // Configuration, static while the console runs
  input  cart_pkg::mapper_t             mapper,
  input  logic [cart_pkg::feat_w-1:0]   featurebits,
  input  logic [cart_pkg::addr_w-1:0]   rom_mask,
  input  logic [cart_pkg::addr_w-1:0]   saveram_mask,
  // External memory
  output logic                          mem_ce,
  output logic                          mem_we,
  output logic [cart_pkg::addr_w-1:0]   mem_addr,
  output logic [cart_pkg::data_w-1:0]   mem_wdata,
  input  logic [cart_pkg::data_w-1:0]   mem_rdata,
  input  logic                          mem_ready,
  // Status
  output logic                          rom_hit,
  output logic                          is_saveram,
  output logic                          is_writable,
  output logic                          msu_enable,
  output logic                          dma_enable,
  output logic                          srtc_enable,
  output logic                          dspx_enable,
  output logic                          dspx_a0,
  output logic                          overrun,
  output logic [cart_pkg::data_w-1:0]   rd_data,
  output logic                          rd_valid
);

  logic [cart_pkg::addr_w-1:0] phys_addr;
  logic                        push;
  cart_pkg::mem_req_t          push_data;
  logic                        credit_return;
  cart_pkg::mem_req_t          head;
  logic                        not_empty;
  logic                        pop;

  address_map address_map_i (
    .CLK, .arst_n, .mapper, .featurebits, .rom_mask, .saveram_mask,
    .snes_addr_early, .snes_romsel_n, .phys_addr, .rom_hit, .is_saveram,
    .is_writable, .msu_enable, .dma_enable, .srtc_enable, .dspx_enable, .dspx_a0
  );

  bus_cycle_ctrl #(.FIFO_DEPTH(FIFO_DEPTH)) bus_cycle_ctrl_i (
    .CLK, .arst_n, .snes_rd_n, .snes_wr_n, .snes_wdata, .phys_addr,
    .rom_hit, .is_writable, .credit_return, .push, .push_data, .overrun
  );

  credit_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) credit_fifo_i (
    .CLK, .arst_n, .push, .push_data, .pop, .head, .not_empty, .credit_return
  );

  sram_port sram_port_i (
    .CLK, .arst_n, .head, .not_empty, .pop, .mem_ce, .mem_we, .mem_addr,
    .mem_wdata, .mem_rdata, .mem_ready, .rd_data, .rd_valid
  );

endmodule

// ==== logic/credit_fifo.sv ====
`timescale 1ns/1ps

module credit_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic               CLK,
  input  logic               arst_n,
  input  logic               push,
  input  cart_pkg::mem_req_t push_data,
  input  logic               pop,
  output cart_pkg::mem_req_t head,
  output logic               not_empty,
  output logic               credit_return
);

  localparam int ptr_w = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int cnt_w = $clog2(FIFO_DEPTH + 1);

  cart_pkg::mem_req_t mem [FIFO_DEPTH];
  logic [ptr_w-1:0]   wr_ptr;
  logic [ptr_w-1:0]   rd_ptr;
  logic [cnt_w-1:0]   count;
  logic               do_pop;

  // Wraps at FIFO_DEPTH, which need not be a power of two
  function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] p);
    ptr_next = (p == ptr_w'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign not_empty     = (count != '0);
  assign do_pop        = pop & not_empty;
  assign head          = mem[rd_ptr];
  assign credit_return = do_pop;   // Slot freed, hand it back to the issuer

  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= ptr_next(wr_ptr);
      if (do_pop) rd_ptr <= ptr_next(rd_ptr);
      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== logic/sram_port.sv ====
`timescale 1ns/1ps

module sram_port (
  input  logic                          CLK,
  input  logic                          arst_n,
  input  cart_pkg::mem_req_t            head,
  input  logic                          not_empty,
  output logic                          pop,
  output logic                          mem_ce,
  output logic                          mem_we,
  output logic [cart_pkg::addr_w-1:0]   mem_addr,
  output logic [cart_pkg::data_w-1:0]   mem_wdata,
  input  logic [cart_pkg::data_w-1:0]   mem_rdata,
  input  logic                          mem_ready,
  output logic [cart_pkg::data_w-1:0]   rd_data,
  output logic                          rd_valid
);

  typedef enum logic {
    ST_IDLE,
    ST_ACCESS
  } state_t;

  state_t state;
  logic   access_done;

  assign pop         = (state == ST_IDLE) & not_empty;
  assign mem_ce      = (state == ST_ACCESS);
  assign access_done = (state == ST_ACCESS) & mem_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Access FSM, one request in flight
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state    <= ST_IDLE;
      mem_we   <= 1'b0;
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (not_empty) begin
            state  <= ST_ACCESS;
            mem_we <= head.write;
          end
        end
        ST_ACCESS: begin
          if (mem_ready) begin
            state    <= ST_IDLE;
            mem_we   <= 1'b0;
            rd_valid <= ~mem_we;   // Reads only
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Address and data pins held for the whole access
  always_ff @(posedge CLK) begin
    if (pop) begin
      mem_addr  <= head.phys_addr;
      mem_wdata <= head.wdata;
    end
    if (access_done && !mem_we) begin
      rd_data <= mem_rdata;
    end
  end

endmodule

// ==== tests/tb_cart_top.sv ====
`timescale 1ns/1ps

module tb_cart_top;

  localparam int FIFO_DEPTH = 4;
  localparam int IDLE_LIMIT = 400;

  typedef struct packed {
    logic                        issue;     // Reaches the memory port
    logic                        hit;
    logic                        writable;
    logic [cart_pkg::addr_w-1:0] phys;
  } access_t;

  logic CLK, arst_n;
  logic [cart_pkg::addr_w-1:0] snes_addr_early, rom_mask, saveram_mask, mem_addr;
  logic snes_rd_n, snes_wr_n, snes_romsel_n, mem_ce, mem_we, mem_ready, rd_valid, overrun;
  logic [7:0] snes_wdata, mem_wdata, mem_rdata, rd_data;
  logic [15:0] featurebits;
  cart_pkg::mapper_t mapper;
  logic rom_hit, is_saveram, is_writable, msu_enable, dma_enable, srtc_enable;
  logic dspx_enable, dspx_a0;

  cart_pkg::mem_req_t exp_q[$];   // Issued console cycles in order
  cart_pkg::mem_req_t done_q[$];  // Completed memory accesses
  logic [7:0] rd_exp[$];
  cart_pkg::mapper_t maps[4] = '{cart_pkg::MAP_HIROM, cart_pkg::MAP_LOROM,
                                 cart_pkg::MAP_EXHIROM, cart_pkg::MAP_MENU};
  integer seed = 32'h60c8_d0fe;
  int done_count = 0;
  logic hold_ready = 1'b0;

  cart_top #(.FIFO_DEPTH(FIFO_DEPTH)) cart_top_i (.*);

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic access_t expected_access(cart_pkg::mapper_t m, logic [23:0] rmask,
                                              logic [23:0] smask, logic [23:0] a, logic wr);
    access_t e;
    logic [23:0] bank, off, sram_off, rom_off;
    logic sram;
    bank = {16'd0, a[23:16]};
    off  = {8'd0, a[15:0]};
    sram = 1'b0;
    sram_off = '0;
    rom_off  = '0;
    case (m)
      cart_pkg::MAP_HIROM, cart_pkg::MAP_EXHIROM: begin
        sram = (bank & 24'h7F) >= 24'h20 && (bank & 24'h7F) <= 24'h3F
            && off >= 24'h6000 && off <= 24'h7FFF;
        sram_off = ((bank & 24'h1F) << 13) | (off & 24'h1FFF);
        if (m == cart_pkg::MAP_HIROM) rom_off = a & 24'h7FFFFF;
        else rom_off = (a[23] ? 24'h0 : 24'h40_0000) | (a & 24'h3FFFFF);  // Low banks go high
      end
      cart_pkg::MAP_LOROM: begin
        sram = (bank & 24'h7F) >= 24'h70 && (a[22] || a[15])
            && (!rmask[21] || off < 24'h8000);
        sram_off = ((bank & 24'h1F) << 15) | (off & 24'h7FFF);
        rom_off  = (a[23] ? 24'h0 : 24'h40_0000) | ((bank & 24'h7F) << 15) | (off & 24'h7FFF);
      end
      cart_pkg::MAP_MENU: begin
        sram     = bank >= 24'hF0;
        sram_off = a & 24'h0FFFFF;
        rom_off  = a & 24'h7FFFFF;
      end
      default: sram = 1'b0;
    endcase
    e.writable = sram;
    e.hit      = a[22] | a[15] | sram;
    e.issue    = e.hit && (!wr || sram);
    if (sram) e.phys = cart_pkg::saveram_base + (sram_off & smask);
    else if (m == cart_pkg::MAP_MENU) e.phys = (rom_off & rmask) + cart_pkg::menu_rom_base;
    else e.phys = rom_off & rmask;
    return e;
  endfunction

  // Order is msu, dma, srtc, dspx enable, dspx_a0
  function automatic logic [4:0] expected_periph(cart_pkg::mapper_t m, logic [15:0] fb,
                                                 logic [23:0] rmask, logic [23:0] a);
    logic [7:0] bank;
    logic [15:0] off;
    logic win, sel;
    bank = a[23:16] & 8'h7F;
    off  = a[15:0];
    win  = 1'b0;
    sel  = 1'b1;
    if (m == cart_pkg::MAP_LOROM) begin
      if (rmask[20]) win = bank >= 8'h60 && bank <= 8'h6F && off < 16'h8000;
      else win = bank >= 8'h30 && bank <= 8'h3F && off >= 16'h8000;
      sel = a[14];
    end else if (m == cart_pkg::MAP_HIROM) begin
      win = bank <= 8'h0F && off >= 16'h6000 && off <= 16'h7FFF;
      sel = a[12];
    end
    return {fb[cart_pkg::FEAT_MSU1] && !a[22] && off >= 16'h2000 && off <= 16'h2007,
            fb[cart_pkg::FEAT_DMA1] && !a[22] && off >= 16'h2020 && off <= 16'h202F,
            fb[cart_pkg::FEAT_SRTC] && !a[22] && off >= 16'h2800 && off <= 16'h2801,
            fb[cart_pkg::FEAT_DSPX] && win,
            fb[cart_pkg::FEAT_DSPX] ? sel : 1'b1};
  endfunction

  function automatic logic [23:0] saveram_addr(cart_pkg::mapper_t m, logic [31:0] r);
    case (m)
      cart_pkg::MAP_HIROM, cart_pkg::MAP_EXHIROM: return {r[31], 2'b01, r[20:16], 3'b011, r[12:0]};
      cart_pkg::MAP_LOROM: return {r[31], 3'b111, r[19:16], 1'b0, r[14:0]};
      default: return {4'hF, r[19:0]};
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checks and stimulus tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] want, input string what);
    if (got !== want) begin
      abort_run($sformatf("Fail at %0t ns: %s, got %0h expected %0h", $time, what, got, want));
    end
  endtask

  task automatic set_config(input cart_pkg::mapper_t m, input logic [23:0] rm,
                            input logic [23:0] sm, input logic [15:0] fb);
    @(posedge CLK);
    mapper       <= m;
    rom_mask     <= rm;
    saveram_mask <= sm;
    featurebits  <= fb;
    repeat (3) @(posedge CLK);  // Mapper decode settles
  endtask

  task automatic console_cycle(input logic [23:0] a, input logic wr, input logic [7:0] d);
    access_t e;
    e = expected_access(mapper, rom_mask, saveram_mask, a, wr);
    if (e.issue) exp_q.push_back(cart_pkg::mem_req_t'({e.phys, wr, d}));
    @(posedge CLK);
    snes_addr_early <= a;
    snes_romsel_n   <= ~(a[22] | a[15]);
    snes_wdata      <= d;
    if (wr) snes_wr_n <= 1'b0;
    else snes_rd_n <= 1'b0;
    repeat (3) @(posedge CLK);
    snes_rd_n <= 1'b1;
    snes_wr_n <= 1'b1;
    repeat (3) @(posedge CLK);
  endtask

  task automatic check_decode(input logic [23:0] a);
    access_t e;
    logic [4:0] p;
    e = expected_access(mapper, rom_mask, saveram_mask, a, 1'b0);
    p = expected_periph(mapper, featurebits, rom_mask, a);
    @(posedge CLK);
    snes_addr_early <= a;
    snes_romsel_n   <= ~(a[22] | a[15]);
    @(posedge CLK);
    @(negedge CLK);
    check_value(rom_hit, e.hit, "rom_hit");
    check_value(is_saveram, e.writable, "is_saveram");
    check_value(is_writable, e.writable, "is_writable");
    check_value({msu_enable, dma_enable, srtc_enable, dspx_enable, dspx_a0}, p,
                "peripheral enables");
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while ((exp_q.size() != 0 || rd_exp.size() != 0 || mem_ce) && n < IDLE_LIMIT) begin
      @(posedge CLK);
      n++;
    end
    if (n >= IDLE_LIMIT) abort_run("Timeout: memory port did not drain in time");
    repeat (2) @(posedge CLK);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Memory model and checker
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge CLK) begin : mem_model
    logic [31:0] r;
    r = $random(seed);
    if (mem_ce && mem_ready) done_q.push_back(cart_pkg::mem_req_t'({mem_addr, mem_we, mem_wdata}));
    if (mem_ce && !hold_ready) mem_ready <= (r[1:0] == 2'b00);  // Random latency
    else mem_ready <= 1'b0;
    if (mem_ce) mem_rdata <= mem_addr[7:0];
  end

  always @(negedge CLK) begin : access_check
    cart_pkg::mem_req_t got, want;
    while (done_q.size() > 0) begin
      got = done_q.pop_front();
      if (exp_q.size() == 0) begin
        abort_run($sformatf("Memory access to %0h with no console cycle behind it", got.phys_addr));
      end else begin
        want = exp_q.pop_front();
        check_value(got.phys_addr, want.phys_addr, "access address");
        check_value(got.write, want.write, "access write flag");
        if (want.write) check_value(got.wdata, want.wdata, "write data");
        else rd_exp.push_back(want.phys_addr[7:0]);
        done_count++;
      end
    end
    if (rd_valid) begin
      if (rd_exp.size() == 0) abort_run("rd_valid pulsed with no read outstanding");
      else check_value(rd_data, rd_exp.pop_front(), "read data");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    logic [31:0] r;
    logic [23:0] a;
    logic [23:0] smasks[3];
    int base;
    smasks = '{24'h001FFF, 24'h0007FF, 24'h01FFFF};
    arst_n = 1'b0;
    snes_addr_early = '0;
    snes_rd_n = 1'b1;
    snes_wr_n = 1'b1;
    snes_wdata = '0;
    snes_romsel_n = 1'b1;
    mapper = cart_pkg::MAP_HIROM;
    featurebits = '0;
    rom_mask = 24'h3FFFFF;
    saveram_mask = 24'h001FFF;
    mem_rdata = '0;
    mem_ready = 1'b0;
    repeat (16) @(posedge CLK);
    arst_n <= 1'b1;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    check_value(mem_ce, 1'b0, "mem_ce after reset");
    check_value(rd_valid, 1'b0, "rd_valid after reset");
    check_value(overrun, 1'b0, "overrun after reset");

    // Random reads per mapper
    foreach (maps[m]) begin
      set_config(maps[m], 24'h3FFFFF, 24'h001FFF, 16'h0000);
      repeat (12) begin
        r = $random(seed);
        console_cycle(r[23:0], 1'b0, 8'h00);
        wait_idle();
      end
    end

    // Save RAM reads and writes, then a write into ROM space
    foreach (maps[m]) begin
      foreach (smasks[s]) begin
        set_config(maps[m], 24'h3FFFFF, smasks[s], 16'h0000);
        repeat (4) begin
          r = $random(seed);
          console_cycle(saveram_addr(maps[m], r), r[30], r[29:22]);
          wait_idle();
        end
        r = $random(seed);
        console_cycle({3'b010, r[20:0]}, 1'b1, r[31:24]);
        wait_idle();
      end
    end

    // Decode and peripheral windows
    repeat (60) begin
      r = $random(seed);
      set_config(maps[r[27:26]], r[28] ? 24'h3FFFFF : (r[29] ? 24'h1FFFFF : 24'h0FFFFF),
                 24'h001FFF, r[15:0]);
      r = $random(seed);
      case (r[25:24])
        2'd0: a = {r[23:16], 10'h080, r[5:0]};
        2'd1: a = {r[23:16], 15'h1400, r[0]};
        2'd2: a = {r[23:16], 3'b011, r[12:0]};
        default: a = r[23:0];
      endcase
      check_decode(a);
    end

    // One request sits in the port and the queue fills behind it
    set_config(cart_pkg::MAP_HIROM, 24'h3FFFFF, 24'h001FFF, 16'h0000);
    base = done_count;
    @(posedge CLK);
    hold_ready <= 1'b1;
    for (int i = 0; i < 6; i++) begin
      r = $random(seed);
      console_cycle({r[23:16], 1'b1, r[14:0]}, 1'b0, 8'h00);
      @(negedge CLK);
      check_value(overrun, i >= FIFO_DEPTH + 1, "overrun during stall");
    end
    while (exp_q.size() > FIFO_DEPTH + 1) void'(exp_q.pop_back());  // Dropped cycle
    @(posedge CLK);
    hold_ready <= 1'b0;
    wait_idle();
    check_value(done_count - base, FIFO_DEPTH + 1, "accesses completed after the stall");
    check_value(overrun, 1'b1, "overrun after the stall");

    if (exp_q.size() == 0 && rd_exp.size() == 0 && done_q.size() == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      abort_run("Expected accesses left unmatched at the end of the run");
    end
  end

endmodule
